// ==== mem_req_arb.f ====
+incdir+hdl
+incdir+test
hdl/bank_req_pkg.sv
hdl/dram_req_pkg.sv
hdl/wb_src_if.sv
hdl/req_fifo.sv
hdl/fill_req_queue.sv
hdl/stride_prefetcher.sv
hdl/wb_req_select.sv
hdl/dram_req_arbiter.sv
hdl/mem_req_top.sv
test/mem_req_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the memory request arbiter testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f mem_req_arb.f \
    --top-module mem_req_tb \
    -Mdir obj_dir \
    -o mem_req_sim

sim_out=$(./obj_dir/mem_req_sim)
echo "$sim_out"

if echo "$sim_out" | grep -qx "Everything OK"; then
    exit 0
fi

echo "Simulation did not report a pass"
exit 1

// ==== test/mem_req_model.svh ====
`ifndef MEM_REQ_MODEL_SVH
`define MEM_REQ_MODEL_SVH

typedef logic [`DRAM_ADDR_WIDTH-1:0]                 addr_t;
typedef logic [`NUM_BANKS-1:0][`DRAM_ADDR_WIDTH-1:0] bank_addrs_t;

// Fill queue entries and the banks of the head already issued
logic [`NUM_BANKS-1:0] mdl_fill_mask [$];
bank_addrs_t           mdl_fill_addr [$];
logic [`NUM_BANKS-1:0] mdl_done;
addr_t                 mdl_pref [$];

int err_count;
int check_count;

task automatic check_value(input string what, input logic [`LINE_WIDTH-1:0] got,
                           input logic [`LINE_WIDTH-1:0] exp);
    check_count++;
    if (got !== exp) begin
        err_count++;
        $display("ERROR at %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
endtask

function automatic int lowest_bit(input logic [`NUM_BANKS-1:0] mask);
    for (int i = 0; i < `NUM_BANKS; i++) begin
        if (mask[i]) begin
            return i;
        end
    end
    return -1;
endfunction

// 3 writeback, 2 fill, 1 prefetch, 0 idle
function automatic int pick_source(input logic [`NUM_BANKS-1:0] wb_mask);
    if (wb_mask != '0) begin
        return 3;
    end else if (mdl_fill_mask.size() > 0) begin
        return 2;
    end else if (mdl_pref.size() > 0) begin
        return 1;
    end
    return 0;
endfunction

function automatic addr_t fill_head_addr();
    return mdl_fill_addr[0][lowest_bit(mdl_fill_mask[0] & ~mdl_done)];
endfunction

// Issue one bank of the head entry and queue its prefetch
task automatic accept_fill();
    int bank;
    bank = lowest_bit(mdl_fill_mask[0] & ~mdl_done);
    if (mdl_pref.size() < `PREF_DEPTH) begin
        mdl_pref.push_back(mdl_fill_addr[0][bank] + addr_t'(`PREF_STRIDE));
    end
    mdl_done[bank] = 1'b1;
    if ((mdl_fill_mask[0] & ~mdl_done) == '0) begin
        void'(mdl_fill_mask.pop_front());
        void'(mdl_fill_addr.pop_front());
        mdl_done = '0;
    end
endtask

`endif

// ==== test/mem_req_tb.sv ====
`timescale 1ns/100ps

`include "cache_defines.svh"

module mem_req_tb;

    localparam int RUN_CYCLES  = 1500;
    localparam int WAIT_LIMIT  = 300;
    localparam int DRAIN_LIMIT = 400;

    logic                                        clk;
    logic                                        arst_n;
    logic [`NUM_BANKS-1:0]                       wb_valid;
    logic [`NUM_BANKS-1:0][`LINE_BYTES-1:0]      wb_byteen;
    logic [`NUM_BANKS-1:0][`DRAM_ADDR_WIDTH-1:0] wb_addr;
    logic [`NUM_BANKS-1:0][`LINE_WIDTH-1:0]      wb_data;
    logic [`NUM_BANKS-1:0]                       wb_ready;
    logic [`NUM_BANKS-1:0]                       fill_valid;
    logic [`NUM_BANKS-1:0][`DRAM_ADDR_WIDTH-1:0] fill_addr;
    logic                                        fill_ready;
    logic                                        dram_req_valid;
    logic                                        dram_req_rw;
    logic [`LINE_BYTES-1:0]                      dram_req_byteen;
    logic [`DRAM_ADDR_WIDTH-1:0]                 dram_req_addr;
    logic [`LINE_WIDTH-1:0]                      dram_req_data;
    logic                                        dram_req_ready;

    integer                seed;
    logic [`NUM_BANKS-1:0] wb_done;
    logic                  fill_done;
    int                    wb_wait [`NUM_BANKS];
    int                    fill_wait;
    int                    timeout_count;
    bit                    timed_out;
    // State of the previous cycle for the stall check
    bit                          stalled_q;
    int                          src_q;
    logic [`NUM_BANKS-1:0]       wb_q;
    logic [`DRAM_ADDR_WIDTH-1:0] addr_q;

    `include "mem_req_model.svh"

    mem_req_top u_mem_req_top (
        .clk             (clk),
        .arst_n          (arst_n),
        .wb_valid        (wb_valid),
        .wb_byteen       (wb_byteen),
        .wb_addr         (wb_addr),
        .wb_data         (wb_data),
        .wb_ready        (wb_ready),
        .fill_valid      (fill_valid),
        .fill_addr       (fill_addr),
        .fill_ready      (fill_ready),
        .dram_req_valid  (dram_req_valid),
        .dram_req_rw     (dram_req_rw),
        .dram_req_byteen (dram_req_byteen),
        .dram_req_addr   (dram_req_addr),
        .dram_req_data   (dram_req_data),
        .dram_req_ready  (dram_req_ready)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    function automatic int unsigned rand_below(input int unsigned range);
        logic [31:0] r;
        r = $random(seed);
        return r % range;
    endfunction

    // Drive on the falling edge, sample shortly before the rising edge
    task automatic run_cycle(input bit new_reqs, input int unsigned ready_pct);
        logic [31:0]           rnd;
        logic [`NUM_BANKS-1:0] wb_ready_exp;
        int                    src;
        int                    bank;
        @(negedge clk);
        for (int i = 0; i < `NUM_BANKS; i++) begin
            if (wb_done[i]) begin
                wb_valid[i] = 1'b0;
                wb_wait[i]  = 0;
            end
            if (new_reqs && !wb_valid[i] && rand_below(100) < 8) begin
                wb_valid[i]  = 1'b1;
                rnd          = $random(seed);
                wb_byteen[i] = rnd[`LINE_BYTES-1:0];
                rnd          = $random(seed);
                wb_addr[i]   = rnd[`DRAM_ADDR_WIDTH-1:0];
                wb_data[i]   = {$random(seed), $random(seed), $random(seed), $random(seed)};
            end
        end
        wb_done = '0;
        if (fill_done) begin
            fill_valid = '0;
            fill_wait  = 0;
        end
        fill_done = 1'b0;
        if (new_reqs && fill_valid == '0 && rand_below(100) < 20) begin
            rnd        = $random(seed);
            fill_valid = rnd[`NUM_BANKS-1:0];
            for (int i = 0; i < `NUM_BANKS; i++) begin
                rnd          = $random(seed);
                fill_addr[i] = rnd[`DRAM_ADDR_WIDTH-1:0];
            end
        end
        dram_req_ready = (rand_below(100) < ready_pct);
        #4;

        src = pick_source(wb_valid);
        bank = lowest_bit(wb_valid);
        check_value("fill_ready", fill_ready, mdl_fill_mask.size() < `DFQ_DEPTH);
        check_value("dram_req_valid", dram_req_valid, src != 0);
        wb_ready_exp = '0;
        if (src == 3) begin
            check_value("writeback rw", dram_req_rw, 1'b1);
            check_value("writeback byteen", dram_req_byteen, wb_byteen[bank]);
            check_value("writeback addr", dram_req_addr, wb_addr[bank]);
            check_value("writeback data", dram_req_data, wb_data[bank]);
            wb_ready_exp[bank] = dram_req_ready;
        end else if (src != 0) begin
            check_value("read rw", dram_req_rw, 1'b0);
            check_value("read byteen", dram_req_byteen, {`LINE_BYTES{1'b1}});
            check_value("read data", dram_req_data, '0);
            if (src == 2) begin
                check_value("fill addr", dram_req_addr, fill_head_addr());
            end else begin
                check_value("prefetch addr", dram_req_addr, mdl_pref[0]);
            end
        end
        check_value("wb_ready", wb_ready, wb_ready_exp);
        if (stalled_q && src == src_q && wb_valid == wb_q) begin
            check_value("stalled request addr", dram_req_addr, addr_q);
        end
        stalled_q = dram_req_valid && !dram_req_ready;
        src_q     = src;
        wb_q      = wb_valid;
        addr_q    = dram_req_addr;

        // Transfers taking place at the coming rising edge
        if (dram_req_ready && src == 3) begin
            wb_done[bank] = 1'b1;
        end else if (dram_req_ready && src == 2) begin
            accept_fill();
        end else if (dram_req_ready && src == 1) begin
            void'(mdl_pref.pop_front());
        end
        if (fill_valid != '0 && fill_ready) begin
            mdl_fill_mask.push_back(fill_valid);
            mdl_fill_addr.push_back(fill_addr);
            fill_done = 1'b1;
        end

        for (int i = 0; i < `NUM_BANKS; i++) begin
            if (wb_valid[i] && !wb_done[i]) begin
                wb_wait[i]++;
                if (wb_wait[i] > WAIT_LIMIT) begin
                    $display("Writeback of bank %0d was never accepted", i);
                    timeout_count++;
                    timed_out = 1'b1;
                end
            end
        end
        if (fill_valid != '0 && !fill_done) begin
            fill_wait++;
            if (fill_wait > WAIT_LIMIT) begin
                $display("Fill entry was never accepted");
                timeout_count++;
                timed_out = 1'b1;
            end
        end
    endtask

    initial begin
        int drain;
        seed           = 29;
        arst_n         = 1'b0;
        wb_valid       = '0;
        wb_byteen      = '0;
        wb_addr        = '0;
        wb_data        = '0;
        fill_valid     = '0;
        fill_addr      = '0;
        dram_req_ready = 1'b0;
        mdl_done       = '0;
        wb_done        = '0;
        fill_done      = 1'b0;
        fill_wait      = 0;
        timeout_count  = 0;
        timed_out      = 1'b0;
        stalled_q      = 1'b0;
        err_count      = 0;
        check_count    = 0;
        for (int i = 0; i < `NUM_BANKS; i++) begin
            wb_wait[i] = 0;
        end

        repeat (3) @(posedge clk);
        #1;
        check_value("dram_req_valid in reset", dram_req_valid, 1'b0);
        check_value("wb_ready in reset", wb_ready, '0);
        check_value("fill_ready in reset", fill_ready, 1'b1);
        @(negedge clk);
        arst_n = 1'b1;

        // A stretch with DRAM stalled lets both queues fill up
        for (int cyc = 0; cyc < RUN_CYCLES && !timed_out; cyc++) begin
            run_cycle(1'b1, (cyc >= 600 && cyc < 660) ? 0 : 70);
        end

        drain = 0;
        while (!timed_out && drain < DRAIN_LIMIT &&
               (wb_valid != '0 || fill_valid != '0 || mdl_fill_mask.size() > 0 ||
                mdl_pref.size() > 0 || dram_req_valid)) begin
            run_cycle(1'b0, 70);
            drain++;
        end
        if (drain >= DRAIN_LIMIT) begin
            $display("Requests did not drain after the stimulus stopped");
            timeout_count++;
        end

        $display("Checks %0d, errors %0d, timeouts %0d", check_count, err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== hdl/mem_req_top.sv ====
`timescale 1ns/100ps

`include "cache_defines.svh"

module mem_req_top (
    input  logic                                         clk,
    input  logic                                         arst_n,
    input  logic [`NUM_BANKS-1:0]                        wb_valid,
    input  logic [`NUM_BANKS-1:0][`LINE_BYTES-1:0]       wb_byteen,
    input  logic [`NUM_BANKS-1:0][`DRAM_ADDR_WIDTH-1:0]  wb_addr,
    input  logic [`NUM_BANKS-1:0][`LINE_WIDTH-1:0]       wb_data,
    output logic [`NUM_BANKS-1:0]                        wb_ready,
    input  logic [`NUM_BANKS-1:0]                        fill_valid,
    input  logic [`NUM_BANKS-1:0][`DRAM_ADDR_WIDTH-1:0]  fill_addr,
    output logic                                         fill_ready,
    output logic                                         dram_req_valid,
    output logic                                         dram_req_rw,
    output logic [`LINE_BYTES-1:0]                       dram_req_byteen,
    output logic [`DRAM_ADDR_WIDTH-1:0]                  dram_req_addr,
    output logic [`LINE_WIDTH-1:0]                       dram_req_data,
    input  logic                                         dram_req_ready
);

    import bank_req_pkg::*;
    import dram_req_pkg::*;

    wb_req_t [`NUM_BANKS-1:0] wb_req;
    logic                     fq_valid;
    line_addr_t               fq_addr;
    logic                     fq_take;
    logic                     pref_valid;
    line_addr_t               pref_addr;
    logic                     pref_take;
    logic                     fill_issued;
    dram_req_t                dram_req;

    wb_src_if u_wb_if ();

    for (genvar i = 0; i < `NUM_BANKS; i++) begin : g_wb_pack
        assign wb_req[i] = '{byteen: wb_byteen[i], addr: wb_addr[i], data: wb_data[i]};
    end

    wb_req_select u_wb_req_select (
        .wb_valid (wb_valid),
        .wb_req   (wb_req),
        .wb_ready (wb_ready),
        .wb       (u_wb_if.sel)
    );

    fill_req_queue u_fill_req_queue (
        .clk        (clk),
        .arst_n     (arst_n),
        .fill_valid (fill_valid),
        .fill_addr  (fill_addr),
        .fill_ready (fill_ready),
        .out_valid  (fq_valid),
        .out_addr   (fq_addr),
        .out_take   (fq_take)
    );

    // Only fill reads feed the prefetcher
    stride_prefetcher u_stride_prefetcher (
        .clk         (clk),
        .arst_n      (arst_n),
        .fill_issued (fill_issued),
        .issued_addr (fq_addr),
        .pref_valid  (pref_valid),
        .pref_addr   (pref_addr),
        .pref_take   (pref_take)
    );

    dram_req_arbiter u_dram_req_arbiter (
        .clk            (clk),
        .arst_n         (arst_n),
        .wb             (u_wb_if.arb),
        .fill_valid     (fq_valid),
        .fill_addr      (fq_addr),
        .fill_take      (fq_take),
        .pref_valid     (pref_valid),
        .pref_addr      (pref_addr),
        .pref_take      (pref_take),
        .fill_issued    (fill_issued),
        .dram_req_valid (dram_req_valid),
        .dram_req       (dram_req),
        .dram_req_ready (dram_req_ready)
    );

    assign dram_req_rw     = dram_req.rw;
    assign dram_req_byteen = dram_req.byteen;
    assign dram_req_addr   = dram_req.addr;
    assign dram_req_data   = dram_req.data;

endmodule

// ==== hdl/dram_req_arbiter.sv ====
`timescale 1ns/100ps

module dram_req_arbiter (
    input  logic                     clk,
    input  logic                     arst_n,
    wb_src_if.arb                    wb,
    input  logic                     fill_valid,
    input  bank_req_pkg::line_addr_t fill_addr,
    output logic                     fill_take,
    input  logic                     pref_valid,
    input  bank_req_pkg::line_addr_t pref_addr,
    output logic                     pref_take,
    output logic                     fill_issued,
    output logic                     dram_req_valid,
    output dram_req_pkg::dram_req_t  dram_req,
    input  logic                     dram_req_ready
);

    import dram_req_pkg::*;

    req_src_e src;

    // Writeback, then fill, then prefetch
    always_comb begin
        if (wb.valid) begin
            src = SRC_WB;
        end else if (fill_valid) begin
            src = SRC_FILL;
        end else if (pref_valid) begin
            src = SRC_PREF;
        end else begin
            src = SRC_NONE;
        end
    end

    assign dram_req_valid = (src != SRC_NONE);

    always_comb begin
        // Reads fetch the whole line
        dram_req.rw     = 1'b0;
        dram_req.byteen = '1;
        dram_req.addr   = pref_addr;
        dram_req.data   = '0;
        unique case (src)
            SRC_WB: begin
                dram_req.rw     = 1'b1;
                dram_req.byteen = wb.req.byteen;
                dram_req.addr   = wb.req.addr;
                dram_req.data   = wb.req.data;
            end
            SRC_FILL: begin
                dram_req.addr = fill_addr;
            end
            SRC_PREF, SRC_NONE: begin
                dram_req.addr = pref_addr;
            end
        endcase
    end

    assign wb.take     = dram_req_ready && (src == SRC_WB);
    assign fill_take   = dram_req_ready && (src == SRC_FILL);
    assign pref_take   = dram_req_ready && (src == SRC_PREF);
    assign fill_issued = fill_take;

    a_one_take: assert property (
        @(posedge clk) disable iff (!arst_n) $onehot0({wb.take, fill_take, pref_take})
    );

    a_take_needs_ready: assert property (
        @(posedge clk) disable iff (!arst_n)
        (wb.take || fill_take || pref_take) |-> dram_req_ready
    );

    // Sources hold their requests while DRAM stalls
    a_valid_held: assert property (
        @(posedge clk) disable iff (!arst_n)
        (dram_req_valid && !dram_req_ready) |=> dram_req_valid
    );

endmodule

// ==== hdl/wb_req_select.sv ====
`timescale 1ns/100ps

`include "cache_defines.svh"

module wb_req_select (
    input  logic [`NUM_BANKS-1:0]                   wb_valid,
    input  bank_req_pkg::wb_req_t [`NUM_BANKS-1:0]  wb_req,
    output logic [`NUM_BANKS-1:0]                   wb_ready,
    wb_src_if.sel                                   wb
);

    import bank_req_pkg::*;

    bank_idx_t sel_bank;
    logic      found;

    // Lowest active bank wins
    always_comb begin
        sel_bank = '0;
        found    = 1'b0;
        for (int i = `NUM_BANKS - 1; i >= 0; i--) begin
            if (wb_valid[i]) begin
                sel_bank = bank_idx_t'(i);
                found    = 1'b1;
            end
        end
    end

    assign wb.valid = found;
    assign wb.bank  = sel_bank;
    assign wb.req   = wb_req[sel_bank];

    // Only the selected bank sees the take
    for (genvar i = 0; i < `NUM_BANKS; i++) begin : g_ready
        assign wb_ready[i] = wb.take && (wb.bank == bank_idx_t'(i));
    end

endmodule

// ==== hdl/stride_prefetcher.sv ====
`timescale 1ns/100ps

`include "cache_defines.svh"

module stride_prefetcher (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     fill_issued,
    input  bank_req_pkg::line_addr_t issued_addr,
    output logic                     pref_valid,
    output bank_req_pkg::line_addr_t pref_addr,
    input  logic                     pref_take
);

    import bank_req_pkg::*;

    line_addr_t next_addr;
    logic       push;
    logic       empty;
    logic       full;

    assign next_addr = issued_addr + line_addr_t'(`PREF_STRIDE);

    // New prefetches are dropped once the queue is full
    assign push = fill_issued && !full;

    req_fifo #(
        .payload_t (line_addr_t),
        .DEPTH     (`PREF_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (push),
        .push_data (next_addr),
        .pop       (pref_take),
        .head      (pref_addr),
        .empty     (empty),
        .full      (full)
    );

    assign pref_valid = !empty;

    a_push_not_full: assert property (
        @(posedge clk) disable iff (!arst_n) push |-> !full
    );

endmodule

// ==== hdl/fill_req_queue.sv ====
`timescale 1ns/100ps

`include "cache_defines.svh"

module fill_req_queue (
    input  logic                                      clk,
    input  logic                                      arst_n,
    input  logic [`NUM_BANKS-1:0]                     fill_valid,
    input  bank_req_pkg::line_addr_t [`NUM_BANKS-1:0] fill_addr,
    output logic                                      fill_ready,
    output logic                                      out_valid,
    output bank_req_pkg::line_addr_t                  out_addr,
    input  logic                                      out_take
);

    import bank_req_pkg::*;

    fill_entry_t head;
    logic        push;
    logic        pop;
    logic        empty;
    logic        full;
    bank_mask_t  done_mask;
    bank_mask_t  pending;
    bank_mask_t  rest;
    bank_idx_t   sel_bank;
    logic        last;

    assign fill_ready = !full;
    assign push       = (|fill_valid) && fill_ready;

    req_fifo #(
        .payload_t (fill_entry_t),
        .DEPTH     (`DFQ_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (push),
        .push_data ('{mask: fill_valid, addr: fill_addr}),
        .pop       (pop),
        .head      (head),
        .empty     (empty),
        .full      (full)
    );

    // Banks of the head entry not yet issued
    assign pending = head.mask & ~done_mask;

    always_comb begin
        sel_bank = '0;
        for (int i = `NUM_BANKS - 1; i >= 0; i--) begin
            if (pending[i]) begin
                sel_bank = bank_idx_t'(i);
            end
        end
        rest           = pending;
        rest[sel_bank] = 1'b0;
    end

    assign last      = ~|rest;
    assign pop       = out_take && last;
    assign out_valid = !empty;
    assign out_addr  = head.addr[sel_bank];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done_mask <= '0;
        end else if (out_take) begin
            done_mask <= last ? '0 : (head.mask & ~rest);
        end
    end

endmodule

// ==== hdl/req_fifo.sv ====
`timescale 1ns/100ps

module req_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     empty,
    output logic     full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            // Simultaneous push and pop keeps the level
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n) pop |-> !empty);
    a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n) push |-> !full);

endmodule

// ==== hdl/wb_src_if.sv ====
`timescale 1ns/100ps

`include "cache_defines.svh"

interface wb_src_if;

    import bank_req_pkg::*;

    logic      valid;
    bank_idx_t bank;
    wb_req_t   req;
    logic      take;

    // Writeback selector side
    modport sel (
        output valid,
        output bank,
        output req,
        input  take
    );

    // Arbiter side
    modport arb (
        input  valid,
        input  bank,
        input  req,
        output take
    );

endinterface

// ==== hdl/dram_req_pkg.sv ====
`include "cache_defines.svh"

package dram_req_pkg;

    // Source granted in the current cycle in rising priority order
    typedef enum logic [1:0] {
        SRC_NONE,
        SRC_PREF,
        SRC_FILL,
        SRC_WB
    } req_src_e;

    // Merged DRAM request
    // rw is high for a write
    typedef struct packed {
        logic                      rw;
        logic [`LINE_BYTES-1:0]    byteen;
        bank_req_pkg::line_addr_t  addr;
        logic [`LINE_WIDTH-1:0]    data;
    } dram_req_t;

endpackage

// ==== hdl/bank_req_pkg.sv ====
`include "cache_defines.svh"

package bank_req_pkg;

    // Line address as seen by DRAM
    typedef logic [`DRAM_ADDR_WIDTH-1:0] line_addr_t;

    typedef logic [`BANK_BITS-1:0] bank_idx_t;

    typedef logic [`NUM_BANKS-1:0] bank_mask_t;

    // Dirty line writeback from one bank
    typedef struct packed {
        logic [`LINE_BYTES-1:0] byteen;
        line_addr_t             addr;
        logic [`LINE_WIDTH-1:0] data;
    } wb_req_t;

    // One fill queue entry
    // Address slots of unmasked banks are don't care
    typedef struct packed {
        bank_mask_t                       mask;
        line_addr_t [`NUM_BANKS-1:0]      addr;
    } fill_entry_t;

endpackage

// ==== hdl/cache_defines.svh ====
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// Cache geometry
`define NUM_BANKS 4
`define LINE_BYTES 16
`define LINE_WIDTH (`LINE_BYTES * 8)
`define DRAM_ADDR_WIDTH 28

// Width of a bank index
`define BANK_BITS $clog2(`NUM_BANKS)

// Queue sizing
`define DFQ_DEPTH 4
`define PREF_DEPTH 4

// Prefetch distance in lines
`define PREF_STRIDE 1

`endif
